/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [29:0] pc_t;      // word address
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG, FWD_MEM, FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } instr_s_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } instr_b_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } instr_u_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } instr_j_t;

    // one instruction word, six views
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_s_t s;
        instr_b_t b;
        instr_u_t u;
        instr_j_t j;
    } instr_u;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;   // operand b from immediate
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    branch_ne;
        logic    jump;
    } ex_ctrl_t;

    typedef struct packed {
        logic     valid;
        pc_t      pc;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        xlen_t    imm;
        ex_ctrl_t ctrl;
    } dec_ex_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        xlen_t    result;   // alu result or link
        xlen_t    store_data;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     reg_write;
        xlen_t    data;
    } mem_wb_t;

endpackage

`default_nettype wire

/* rv_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_fetch
    import rv_pkg::*;
#(
    parameter xlen_t reset_addr = 32'h0000_0000
)
(
    input  wire      i_clk,
    input  wire      i_rst,
    input  wire      i_hold,
    input  wire      i_redirect,
    input  wire pc_t i_target,
    output pc_t      o_pc
);

    pc_t r_pc;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
            r_pc <= reset_addr[31:2];
        else if (i_redirect)
            r_pc <= i_target;       // wins over hold
        else if (!i_hold)
            r_pc <= r_pc + 30'd1;
    end

    assign o_pc = r_pc;

endmodule

`default_nettype wire

/* rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode
    import rv_pkg::*;
(
    input  wire         i_clk,
    input  wire         i_rst,
    input  wire         i_hold,
    input  wire         i_flush,
    input  wire instr_u i_instr,
    input  wire         i_fetch_done,
    input  wire pc_t    i_pc,
    output dec_ex_t     o_dec
);

    logic     r_valid;
    instr_u   r_instr;
    pc_t      r_pc;
    ex_ctrl_t w_ctrl;
    xlen_t    w_imm;
    xlen_t    w_imm_i;
    xlen_t    w_imm_s;
    xlen_t    w_imm_b;
    xlen_t    w_imm_u;
    xlen_t    w_imm_j;

    function automatic alu_op_e alu_from_funct(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b101:  return ALU_SRL;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    always_ff @(posedge i_clk)
    begin
        if (i_rst || i_flush)
        begin
            r_valid <= 1'b0;
        end
        else if (!i_hold)
        begin
            r_valid <= i_fetch_done;    // no fetch, bubble
            r_instr <= i_instr;
            r_pc    <= i_pc;
        end
    end

    assign w_imm_i = {{20{r_instr.i.imm[11]}}, r_instr.i.imm};
    assign w_imm_s = {{20{r_instr.s.imm_hi[6]}}, r_instr.s.imm_hi, r_instr.s.imm_lo};
    assign w_imm_b = {{19{r_instr.b.imm12}}, r_instr.b.imm12, r_instr.b.imm11,
                      r_instr.b.imm10_5, r_instr.b.imm4_1, 1'b0};
    assign w_imm_u = {r_instr.u.imm, 12'b0};
    assign w_imm_j = {{11{r_instr.j.imm20}}, r_instr.j.imm20, r_instr.j.imm19_12,
                      r_instr.j.imm11, r_instr.j.imm10_1, 1'b0};

    always_comb
    begin
        w_ctrl = '0;
        w_imm  = w_imm_i;
        case (opcode_e'(r_instr.r.opcode))
            OPC_OP:
            begin
                w_ctrl.alu_op    = alu_from_funct(r_instr.r.funct3, r_instr.r.funct7[5]);
                w_ctrl.reg_write = 1'b1;
            end
            OPC_OP_IMM:
            begin
                w_ctrl.alu_op    = alu_from_funct(r_instr.i.funct3, 1'b0);
                w_ctrl.use_imm   = 1'b1;
                w_ctrl.reg_write = 1'b1;
            end
            OPC_LUI:
            begin
                w_imm            = w_imm_u;
                w_ctrl.alu_op    = ALU_PASS_B;
                w_ctrl.use_imm   = 1'b1;
                w_ctrl.reg_write = 1'b1;
            end
            OPC_LOAD:
            begin
                w_ctrl.use_imm   = 1'b1;
                w_ctrl.reg_write = 1'b1;
                w_ctrl.mem_read  = 1'b1;
            end
            OPC_STORE:
            begin
                w_imm            = w_imm_s;
                w_ctrl.use_imm   = 1'b1;
                w_ctrl.mem_write = 1'b1;
            end
            OPC_BRANCH:
            begin
                w_imm            = w_imm_b;
                w_ctrl.branch    = 1'b1;
                w_ctrl.branch_ne = r_instr.b.funct3[0];   // bne
            end
            OPC_JAL:
            begin
                w_imm            = w_imm_j;
                w_ctrl.alu_op    = ALU_PASS_B;
                w_ctrl.reg_write = 1'b1;
                w_ctrl.jump      = 1'b1;
            end
            default: ;  // no-op
        endcase
    end

    always_comb
    begin
        o_dec.valid = r_valid;
        o_dec.pc    = r_pc;
        o_dec.rs1   = r_instr.r.rs1;
        o_dec.rs2   = r_instr.r.rs2;
        o_dec.rd    = r_instr.r.rd;
        o_dec.imm   = w_imm;
        o_dec.ctrl  = w_ctrl;
    end

endmodule

`default_nettype wire

/* rv_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regs
    import rv_pkg::*;
(
    input  wire           i_clk,
    input  wire reg_idx_t i_rs1,
    input  wire reg_idx_t i_rs2,
    input  wire mem_wb_t  i_wb,
    output xlen_t         o_rs1_val,
    output xlen_t         o_rs2_val
);

    xlen_t r_file [32];
    logic  w_write;

    function automatic xlen_t read_port(input reg_idx_t idx);
        if (idx == '0)
            return '0;
        else if (w_write && i_wb.rd == idx)
            return i_wb.data;   // write-through
        else
            return r_file[idx];
    endfunction

    assign w_write = i_wb.valid & i_wb.reg_write & (i_wb.rd != '0);

    always_ff @(posedge i_clk)
    begin
        if (w_write)
            r_file[i_wb.rd] <= i_wb.data;
    end

    always_comb
    begin
        o_rs1_val = read_port(i_rs1);
        o_rs2_val = read_port(i_rs2);
    end

endmodule

`default_nettype wire

/* rv_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_exec
    import rv_pkg::*;
(
    input  wire           i_clk,
    input  wire           i_rst,
    input  wire           i_hold,
    input  wire           i_flush,
    input  wire dec_ex_t  i_dec,
    input  wire xlen_t    i_rs1_val,
    input  wire xlen_t    i_rs2_val,
    input  wire fwd_sel_e i_fwd_rs1,
    input  wire fwd_sel_e i_fwd_rs2,
    input  wire xlen_t    i_mem_val,
    input  wire mem_wb_t  i_wb,
    output ex_mem_t       o_ex,
    output dec_ex_t       o_stage,
    output logic          o_redirect,
    output pc_t           o_target
);

    dec_ex_t r_stage;
    xlen_t   r_rs1_val;
    xlen_t   r_rs2_val;
    xlen_t   w_op_a;
    xlen_t   w_op_b;
    xlen_t   w_alu_b;
    xlen_t   w_alu_res;
    pc_t     w_link;
    logic    w_taken;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            r_stage.valid <= 1'b0;
        end
        else if (i_hold)
        begin
            // producer may leave write stage while we wait
            r_rs1_val <= w_op_a;
            r_rs2_val <= w_op_b;
        end
        else
        begin
            r_stage       <= i_dec;
            r_stage.valid <= i_dec.valid & ~i_flush;
            r_rs1_val     <= i_rs1_val;
            r_rs2_val     <= i_rs2_val;
        end
    end

    always_comb
    begin
        case (i_fwd_rs1)
            FWD_MEM: w_op_a = i_mem_val;
            FWD_WB:  w_op_a = i_wb.data;
            default: w_op_a = r_rs1_val;
        endcase
        case (i_fwd_rs2)
            FWD_MEM: w_op_b = i_mem_val;
            FWD_WB:  w_op_b = i_wb.data;
            default: w_op_b = r_rs2_val;
        endcase
    end

    assign w_alu_b = r_stage.ctrl.use_imm ? r_stage.imm : w_op_b;

    always_comb
    begin
        case (r_stage.ctrl.alu_op)
            ALU_ADD:    w_alu_res = w_op_a + w_alu_b;
            ALU_SUB:    w_alu_res = w_op_a - w_alu_b;
            ALU_AND:    w_alu_res = w_op_a & w_alu_b;
            ALU_OR:     w_alu_res = w_op_a | w_alu_b;
            ALU_XOR:    w_alu_res = w_op_a ^ w_alu_b;
            ALU_SLT:    w_alu_res = {31'b0, $signed(w_op_a) < $signed(w_alu_b)};
            ALU_SLL:    w_alu_res = w_op_a << w_alu_b[4:0];
            ALU_SRL:    w_alu_res = w_op_a >> w_alu_b[4:0];
            ALU_PASS_B: w_alu_res = w_alu_b;
            default:    w_alu_res = '0;
        endcase
    end

    assign w_taken    = r_stage.ctrl.branch & (r_stage.ctrl.branch_ne ^ (w_op_a == w_op_b));
    assign w_link     = r_stage.pc + 30'd1;
    assign o_target   = r_stage.pc + r_stage.imm[31:2];
    assign o_redirect = r_stage.valid & (w_taken | r_stage.ctrl.jump);
    assign o_stage    = r_stage;

    always_comb
    begin
        o_ex.valid      = r_stage.valid;
        o_ex.rd         = r_stage.rd;
        o_ex.result     = r_stage.ctrl.jump ? {w_link, 2'b00} : w_alu_res;
        o_ex.store_data = w_op_b;
        o_ex.reg_write  = r_stage.ctrl.reg_write;
        o_ex.mem_read   = r_stage.ctrl.mem_read;
        o_ex.mem_write  = r_stage.ctrl.mem_write;
    end

endmodule

`default_nettype wire

/* rv_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_memory
    import rv_pkg::*;
(
    input  wire          i_clk,
    input  wire          i_rst,
    input  wire          i_hold,
    input  wire ex_mem_t i_ex,
    input  wire xlen_t   i_rdata,
    output ex_mem_t      o_mem,
    output mem_wb_t      o_wb
);

    ex_mem_t r_mem;
    mem_wb_t r_wb;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            r_mem.valid <= 1'b0;
            r_wb.valid  <= 1'b0;
        end
        else
        begin
            if (!i_hold)
                r_mem <= i_ex;
            // access still pending, write stage gets a bubble
            r_wb.valid     <= r_mem.valid & ~i_hold;
            r_wb.rd        <= r_mem.rd;
            r_wb.reg_write <= r_mem.reg_write;
            r_wb.data      <= r_mem.mem_read ? i_rdata : r_mem.result;
        end
    end

    assign o_mem = r_mem;
    assign o_wb  = r_wb;

endmodule

`default_nettype wire

/* rv_hazard.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_hazard
    import rv_pkg::*;
(
    input  wire dec_ex_t i_dec,
    input  wire dec_ex_t i_ex_stage,
    input  wire ex_mem_t i_mem,
    input  wire mem_wb_t i_wb,
    input  wire          i_redirect,
    input  wire          i_bus_ack,
    output fwd_sel_e     o_fwd_rs1,
    output fwd_sel_e     o_fwd_rs2,
    output logic         o_fetch_hold,
    output logic         o_dec_hold,
    output logic         o_dec_flush,
    output logic         o_ex_hold,
    output logic         o_ex_flush,
    output logic         o_mem_hold
);

    logic w_data_access;
    logic w_data_stall;
    logic w_load_use;

    // memory stage is the younger producer, so it wins
    function automatic fwd_sel_e fwd_src(input reg_idx_t rs, input ex_mem_t mem,
                                         input mem_wb_t wb);
        if (rs != '0 && mem.valid && mem.reg_write && mem.rd == rs)
            return FWD_MEM;
        else if (rs != '0 && wb.valid && wb.reg_write && wb.rd == rs)
            return FWD_WB;
        else
            return FWD_REG;
    endfunction

    assign o_fwd_rs1 = fwd_src(i_ex_stage.rs1, i_mem, i_wb);
    assign o_fwd_rs2 = fwd_src(i_ex_stage.rs2, i_mem, i_wb);

    assign w_data_access = i_mem.valid & (i_mem.mem_read | i_mem.mem_write);
    assign w_data_stall  = w_data_access & ~i_bus_ack;

    assign w_load_use = i_ex_stage.valid & i_ex_stage.ctrl.mem_read & (i_ex_stage.rd != '0)
                      & i_dec.valid
                      & ((i_ex_stage.rd == i_dec.rs1) | (i_ex_stage.rd == i_dec.rs2));

    // fetch waits for its own ack and for a free bus
    assign o_fetch_hold = w_data_access | ~i_bus_ack | w_load_use;
    assign o_dec_hold   = w_data_stall | w_load_use;
    // redirect stays up while execute is held, flush once it moves
    assign o_dec_flush  = i_redirect & ~w_data_stall;
    assign o_ex_hold    = w_data_stall;
    assign o_ex_flush   = (i_redirect | w_load_use) & ~w_data_stall;
    assign o_mem_hold   = w_data_stall;

endmodule

`default_nettype wire

/* rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core
    import rv_pkg::*;
#(
    parameter xlen_t reset_addr = 32'h0000_0000
)
(
    input  wire        i_clk,
    input  wire        i_rst,
    output xlen_t      o_wb_adr,
    output xlen_t      o_wb_dat,
    output logic       o_wb_we,
    input  wire xlen_t i_wb_dat,
    input  wire        i_wb_ack
);

    pc_t      w_pc;
    dec_ex_t  w_dec;
    dec_ex_t  w_ex_stage;
    ex_mem_t  w_ex;
    ex_mem_t  w_mem;
    mem_wb_t  w_wb;
    xlen_t    w_rs1_val;
    xlen_t    w_rs2_val;
    fwd_sel_e w_fwd_rs1;
    fwd_sel_e w_fwd_rs2;
    logic     w_redirect;
    pc_t      w_target;
    logic     w_fetch_hold;
    logic     w_dec_hold;
    logic     w_dec_flush;
    logic     w_ex_hold;
    logic     w_ex_flush;
    logic     w_mem_hold;
    logic     w_data_access;
    logic     w_fetch_done;

    rv_fetch #(
        .reset_addr (reset_addr)
    ) u_fetch (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_hold     (w_fetch_hold),
        .i_redirect (w_redirect),
        .i_target   (w_target),
        .o_pc       (w_pc)
    );

    rv_decode u_decode (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_hold       (w_dec_hold),
        .i_flush      (w_dec_flush),
        .i_instr      (instr_u'(i_wb_dat)),
        .i_fetch_done (w_fetch_done),
        .i_pc         (w_pc),
        .o_dec        (w_dec)
    );

    rv_regs u_regs (
        .i_clk     (i_clk),
        .i_rs1     (w_dec.rs1),
        .i_rs2     (w_dec.rs2),
        .i_wb      (w_wb),
        .o_rs1_val (w_rs1_val),
        .o_rs2_val (w_rs2_val)
    );

    rv_exec u_exec (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_hold     (w_ex_hold),
        .i_flush    (w_ex_flush),
        .i_dec      (w_dec),
        .i_rs1_val  (w_rs1_val),
        .i_rs2_val  (w_rs2_val),
        .i_fwd_rs1  (w_fwd_rs1),
        .i_fwd_rs2  (w_fwd_rs2),
        .i_mem_val  (w_mem.result),
        .i_wb       (w_wb),
        .o_ex       (w_ex),
        .o_stage    (w_ex_stage),
        .o_redirect (w_redirect),
        .o_target   (w_target)
    );

    rv_memory u_memory (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_hold  (w_mem_hold),
        .i_ex    (w_ex),
        .i_rdata (i_wb_dat),
        .o_mem   (w_mem),
        .o_wb    (w_wb)
    );

    rv_hazard u_hazard (
        .i_dec        (w_dec),
        .i_ex_stage   (w_ex_stage),
        .i_mem        (w_mem),
        .i_wb         (w_wb),
        .i_redirect   (w_redirect),
        .i_bus_ack    (i_wb_ack),
        .o_fwd_rs1    (w_fwd_rs1),
        .o_fwd_rs2    (w_fwd_rs2),
        .o_fetch_hold (w_fetch_hold),
        .o_dec_hold   (w_dec_hold),
        .o_dec_flush  (w_dec_flush),
        .o_ex_hold    (w_ex_hold),
        .o_ex_flush   (w_ex_flush),
        .o_mem_hold   (w_mem_hold)
    );

    // data access owns the bus, fetch gets the rest
    assign w_data_access = w_mem.valid & (w_mem.mem_read | w_mem.mem_write);
    assign w_fetch_done  = i_wb_ack & ~w_data_access;

    assign o_wb_adr = w_data_access ? w_mem.result : {w_pc, 2'b00};
    assign o_wb_dat = w_mem.store_data;
    assign o_wb_we  = w_data_access & w_mem.mem_write;

endmodule

`default_nettype wire

/* core_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module core_assert
    import rv_pkg::*;
(
    input wire        i_clk,
    input wire        i_rst,
    input wire xlen_t i_wb_adr,
    input wire xlen_t i_wb_dat,
    input wire        i_wb_we
);

    int n_errors = 0;   // failures so far

    // word bus only
    adr_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wb_adr[1:0] == 2'b00)
        else
        begin
            $error("bus address %08h is not word aligned", i_wb_adr);
            n_errors++;
        end

    we_low_after_reset: assert property (@(posedge i_clk) i_rst |=> !i_wb_we)
        else
        begin
            $error("write enable high in reset or on the first edge after it");
            n_errors++;
        end

    dat_known: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wb_we |-> !$isunknown(i_wb_dat))
        else
        begin
            $error("write data has unknown bits while write enable is high");
            n_errors++;
        end

endmodule

bind rv_core core_assert u_core_assert (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_wb_adr (o_wb_adr),
    .i_wb_dat (o_wb_dat),
    .i_wb_we  (o_wb_we)
);

`default_nettype wire

/* tb_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_core
    import rv_pkg::*;
();

    localparam xlen_t      start_addr = 32'h0000_0000;
    localparam xlen_t      done_addr  = 32'h0000_03fc;
    localparam logic [6:0] opc_imm    = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;

    logic        i_clk    = 1'b0;
    logic        i_rst    = 1'b1;
    logic        i_wb_ack = 1'b0;
    xlen_t       i_wb_dat;
    xlen_t       o_wb_adr;
    xlen_t       o_wb_dat;
    logic        o_wb_we;

    logic [31:0] rng_state    = 32'hd04d_8840;
    xlen_t       mem [256];         // bus memory
    xlen_t       model_mem [256];
    xlen_t       model_regs [32];
    logic        model_done   = 1'b0;
    xlen_t       exp_adr [$];
    xlen_t       exp_dat [$];
    int          n_instr      = 0;
    int          wr_idx       = 0;
    int          limit_cycles = 0;

    rv_core #(
        .reset_addr (start_addr)
    ) rv_core_i (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .o_wb_adr (o_wb_adr),
        .o_wb_dat (o_wb_dat),
        .o_wb_we  (o_wb_we),
        .i_wb_dat (i_wb_dat),
        .i_wb_ack (i_wb_ack)
    );

    always #20 i_clk = ~i_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic reg_idx_t pick_reg();
        return reg_idx_t'(1 + next_rand() % 15);    // x1..x15
    endfunction

    function automatic logic [11:0] data_slot(input int k);
        return 12'h280 + 12'(4 * (k % 64));
    endfunction

    function automatic xlen_t op_word(input logic [6:0] f7, input reg_idx_t rs2,
                                      input reg_idx_t rs1, input logic [2:0] f3,
                                      input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic xlen_t imm_word(input logic [11:0] imm, input reg_idx_t rs1,
                                       input logic [2:0] f3, input reg_idx_t rd,
                                       input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic xlen_t store_word(input logic [11:0] imm, input reg_idx_t rs2,
                                         input reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic xlen_t branch_word(input logic [12:0] off, input reg_idx_t rs2,
                                          input reg_idx_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic xlen_t lui_word(input logic [19:0] imm, input reg_idx_t rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic xlen_t jal_word(input logic [20:0] off, input reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // register, immediate or lui form picked at random
    function automatic xlen_t random_alu(input reg_idx_t rd, input reg_idx_t rs1,
                                         input reg_idx_t rs2);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [11:0] imm;
        r  = next_rand();
        f3 = r[6:4];
        if (f3 == 3'b011)
            f3 = 3'b000;    // no sltu
        imm = r[31:20];
        if (f3 == 3'b001 || f3 == 3'b101)
            imm = {7'b0, r[24:20]};
        if (r[2:0] == 3'd7)
            return lui_word(r[31:12], rd);
        else if (r[2])
            return imm_word(imm, rs1, f3, rd, opc_imm);
        else
            return op_word((f3 == 3'b000 && r[3]) ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
    endfunction

    task automatic append_instr(input xlen_t w);
        model_mem[n_instr] = w;
        n_instr++;
    endtask

    task automatic build_program();
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        xlen_t    rnd;
        int       slot;
        slot = 0;
        for (int r = 1; r < 16; r++)
        begin
            rnd = next_rand();
            append_instr(lui_word(rnd[31:12], reg_idx_t'(r)));
            append_instr(imm_word(rnd[11:0], reg_idx_t'(r), 3'b000, reg_idx_t'(r), opc_imm));
        end
        for (int k = 0; k < 24; k++)
        begin
            rd = pick_reg();
            append_instr(random_alu(rd, pick_reg(), pick_reg()));
            append_instr(store_word(data_slot(slot), rd, 5'd0));
            slot++;
        end
        for (int k = 0; k < 4; k++)
        begin
            rs1 = pick_reg();
            rs2 = pick_reg();
            rd  = pick_reg();
            rnd = next_rand();
            append_instr(imm_word(data_slot(int'(rnd[5:0])), 5'd0, 3'b010, rs1, opc_load));
            // consumer right behind the load
            if (rnd[9])
                append_instr(op_word(7'h00, rs1, rs2, rnd[8] ? 3'b000 : 3'b100, rd));
            else
                append_instr(op_word(7'h00, rs2, rs1, rnd[8] ? 3'b000 : 3'b100, rd));
            append_instr(store_word(data_slot(slot), rd, 5'd0));
            slot++;
        end
        append_instr(imm_word(12'd3, 5'd0, 3'b000, 5'd20, opc_imm));
        append_instr(imm_word(12'd0, 5'd0, 3'b000, 5'd21, opc_imm));
        append_instr(imm_word(12'd5, 5'd21, 3'b000, 5'd21, opc_imm));  // loop head
        append_instr(branch_word(13'd8, 5'd0, 5'd21, 3'b000));         // beq, never taken
        append_instr(store_word(data_slot(slot), 5'd21, 5'd0));
        append_instr(imm_word(12'hfff, 5'd20, 3'b000, 5'd20, opc_imm));
        append_instr(branch_word(13'h1ff0, 5'd0, 5'd20, 3'b001));      // bne back by 16
        append_instr(store_word(data_slot(slot + 1), 5'd21, 5'd0));
        append_instr(store_word(data_slot(slot + 2), 5'd20, 5'd0));
        slot = slot + 3;
        append_instr(jal_word(21'd8, 5'd22));
        append_instr(store_word(data_slot(slot), 5'd1, 5'd0));       // jumped over
        append_instr(store_word(data_slot(slot + 1), 5'd22, 5'd0));  // link value
        append_instr(imm_word(12'h5a5, 5'd0, 3'b000, 5'd23, opc_imm));
        append_instr(store_word(done_addr[11:0], 5'd23, 5'd0));
        append_instr(jal_word(21'd0, 5'd0));
    endtask

    function automatic xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input xlen_t a, input xlen_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // one instruction on the model state, returns the next pc
    function automatic logic [31:0] ref_step(input logic [31:0] pc);
        xlen_t       w;
        xlen_t       a;
        xlen_t       b;
        xlen_t       imm_i;
        xlen_t       imm_s;
        xlen_t       imm_b;
        xlen_t       imm_j;
        xlen_t       ea;
        xlen_t       res;
        logic        wr;
        logic [31:0] next;
        w     = model_mem[pc[9:2]];
        a     = model_regs[w[19:15]];
        b     = model_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        res   = '0;
        wr    = 1'b0;
        next  = pc + 4;
        case (w[6:0])
            7'b0110011:
            begin
                res = alu_ref(w[14:12], w[30], a, b);
                wr  = 1'b1;
            end
            7'b0010011:
            begin
                res = alu_ref(w[14:12], 1'b0, a, imm_i);
                wr  = 1'b1;
            end
            7'b0110111:
            begin
                res = {w[31:12], 12'b0};
                wr  = 1'b1;
            end
            7'b0000011:
            begin
                ea  = a + imm_i;
                res = model_mem[ea[9:2]];
                wr  = 1'b1;
            end
            7'b0100011:
            begin
                ea = a + imm_s;
                model_mem[ea[9:2]] = b;
                exp_adr.push_back(ea);
                exp_dat.push_back(b);
                if (ea == done_addr)
                    model_done = 1'b1;
            end
            7'b1100011:
            begin
                if ((a == b) != w[12])
                    next = pc + imm_b;
            end
            7'b1101111:
            begin
                res  = pc + 4;
                wr   = 1'b1;
                next = pc + imm_j;
            end
            default: ;
        endcase
        if (wr && w[11:7] != 5'd0)
            model_regs[w[11:7]] = res;
        return next;
    endfunction

    task automatic check_word(input string what, input xlen_t got, input xlen_t exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t: %s is %08h, expected %08h", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopping on first mismatch");
        end
    endtask

    assign i_wb_dat = mem[o_wb_adr[9:2]];

    always @(negedge i_clk)
        i_wb_ack <= (next_rand() % 4) != 0;     // about 3 in 4

    always @(posedge i_clk)
    begin
        if (!i_rst && i_wb_ack && o_wb_we)
            mem[o_wb_adr[9:2]] <= o_wb_dat;
    end

    always @(posedge i_clk)
    begin
        if (!i_rst && i_wb_ack && o_wb_we)
        begin
            if (wr_idx >= exp_adr.size())
            begin
                $display("bus write to %08h after the last expected store", o_wb_adr);
                $display("TEST RESULT: FAIL");
                $fatal(1, "extra store on the bus");
            end
            else
            begin
                check_word($sformatf("store %0d address", wr_idx), o_wb_adr, exp_adr[wr_idx]);
                check_word($sformatf("store %0d data", wr_idx), o_wb_dat, exp_dat[wr_idx]);
                wr_idx++;
                if (o_wb_adr == done_addr)
                begin
                    $display("TEST RESULT: PASS");
                    $finish;
                end
            end
        end
    end

    initial
    begin
        wait (rv_core_i.u_core_assert.n_errors != 0);
        $display("a bus assertion failed at %0t", $time);
        $display("TEST RESULT: FAIL");
        $fatal(1, "bus assertion failed");
    end

    initial
    begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge i_clk);
        $display("timeout, no done store within %0d cycles", limit_cycles);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        logic [31:0] pc_m;
        int          steps;
        for (int i = 0; i < 256; i++)
            model_mem[i] = (xlen_t'(i) * 32'h9e37_79b9) ^ 32'h0f1e_2d3c;
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;
        build_program();
        for (int i = 0; i < 256; i++)
            mem[i] = model_mem[i];
        pc_m  = start_addr;
        steps = 0;
        while (!model_done && steps < 4000)
        begin
            pc_m = ref_step(pc_m);
            steps++;
        end
        if (!model_done)
        begin
            $display("reference model did not reach the done store in %0d steps", steps);
            $display("TEST RESULT: FAIL");
            $fatal(1, "bad program image");
        end
        else
        begin
            limit_cycles = steps * 12 + 8;
            repeat (8) @(negedge i_clk);
            i_rst = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* files.f */
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regs.sv
rv_exec.sv
rv_memory.sv
rv_hazard.sv
rv_core.sv
core_assert.sv
tb_core.sv
